// ==== logic/stepper_cfg.svh ====
`ifndef STEPPER_CFG_SVH
`define STEPPER_CFG_SVH

// Command header codes, top byte of a header word
`define CMD_MOVE        8'h01
`define CMD_ENABLE      8'h0a
`define CMD_CLK_DIVISOR 8'h0b
`define CMD_API_VERSION 8'hfe

// API version reported to the host
`define VERSION_MAJOR 8'd0
`define VERSION_MINOR 8'd1
`define VERSION_PATCH 8'd0

// Move buffer depth, power of two
`define MOVE_QUEUE_DEPTH 4

// Accumulator drop per step
`define STEP_THRESHOLD 64'h7fffffffffffff9b

// Divisor out of reset
`define DEFAULT_CLK_DIVISOR 8'd40

`endif

// ==== logic/stepper_pkg.sv ====
package stepper_pkg;

  // One SPI transfer
  typedef logic [63:0] word_t;

  // Command code in the top byte of a header word
  typedef logic [7:0] header_t;

  // Encoder position and signed rate values
  typedef logic signed [63:0] count_t;

  // DDA clock divisor
  typedef logic [7:0] divisor_t;

  // One coordinated move as buffered in the queue
  typedef struct packed {
    logic               dir;
    // Move length in DDA ticks
    logic [63:0]        duration;
    // Step rate on the first tick
    logic signed [63:0] increment;
    // Rate change on each later tick
    logic signed [63:0] increment_increment;
  } move_t;

  // Host-writable settings
  typedef struct packed {
    logic     enable;
    divisor_t clk_divisor;
  } settings_t;

endpackage

// ==== logic/spi_word_rx.sv ====
`timescale 1ns/1ps

module spi_word_rx (
  input  logic               CLK,
  input  logic               rst,
  input  logic               sck,
  input  logic               cs,
  input  logic               copi,
  output logic               cipo,
  input  stepper_pkg::word_t send_word,
  output stepper_pkg::word_t rx_word,
  output logic               word_valid
);

  // Pin synchronizers, bit 1 is the safe copy
  logic [1:0] sck_sync;
  logic [1:0] cs_sync;
  logic [1:0] copi_sync;
  // Last synchronized levels for edge detect
  logic sck_prev;
  logic cs_prev;
  logic sck_rise;
  logic sck_fall;
  logic cs_rise;
  logic cs_fall;
  logic selected;
  // Shift registers and frame length
  stepper_pkg::word_t rx_shift;
  stepper_pkg::word_t tx_shift;
  logic [6:0] bit_count;

  // Synchronizers settle while reset is held
  always_ff @(posedge CLK) begin
    sck_sync  <= {sck_sync[0], sck};
    cs_sync   <= {cs_sync[0], cs};
    copi_sync <= {copi_sync[0], copi};
    sck_prev  <= sck_sync[1];
    cs_prev   <= cs_sync[1];
  end

  assign sck_rise = sck_sync[1] && !sck_prev;
  assign sck_fall = !sck_sync[1] && sck_prev;
  assign cs_rise  = cs_sync[1] && !cs_prev;
  assign cs_fall  = !cs_sync[1] && cs_prev;
  assign selected = !cs_sync[1];

  // MSB first out
  assign cipo = tx_shift[63];

  // Frame length and word strobe
  always_ff @(posedge CLK) begin
    if (rst) begin
      bit_count  <= '0;
      word_valid <= 1'b0;
    end else begin
      // Only a full 64-bit frame counts
      word_valid <= cs_rise && (bit_count == 7'd64);
      if (cs_fall) begin
        bit_count <= '0;
      end else if (sck_rise && selected && (bit_count != 7'h7f)) begin
        // Saturate so long frames never alias to 64
        bit_count <= bit_count + 7'd1;
      end
    end
  end

  // Shift data, mode 0
  always_ff @(posedge CLK) begin
    if (cs_fall) begin
      tx_shift <= send_word;
    end else if (sck_fall && selected) begin
      tx_shift <= {tx_shift[62:0], 1'b0};
    end
    if (sck_rise && selected) begin
      rx_shift <= {rx_shift[62:0], copi_sync[1]};
    end
    // Capture on CS release, aligned with word_valid
    if (cs_rise) begin
      rx_word <= rx_shift;
    end
  end

  // Strobe is one cycle per frame
  assert property (@(posedge CLK) disable iff (rst) word_valid |=> !word_valid);

endmodule

// ==== logic/command_decoder.sv ====
`timescale 1ns/1ps
`include "stepper_cfg.svh"

module command_decoder (
  input  logic                   CLK,
  input  logic                   rst,
  input  logic                   word_valid,
  input  stepper_pkg::word_t     rx_word,
  input  stepper_pkg::count_t    encoder_count,
  output stepper_pkg::word_t     send_word,
  output logic                   push,
  output stepper_pkg::move_t     move,
  output stepper_pkg::settings_t settings
);

  // Waiting for a header, move words or a dummy word
  typedef enum logic [1:0] {
    ST_HEADER,
    ST_MOVE,
    ST_DUMMY
  } state_t;

  state_t state;
  // Follow-up word number within a move
  logic [1:0] word_idx;
  // Version reply owed for the next frame
  logic version_pending;
  logic version_next;
  stepper_pkg::header_t rx_header;
  stepper_pkg::word_t version_word;

  assign rx_header    = rx_word[63:56];
  assign version_word = {40'd0, `VERSION_MAJOR, `VERSION_MINOR, `VERSION_PATCH};

  // Reply choice, decided by each received word
  always_comb begin
    version_next = version_pending;
    if (word_valid) begin
      version_next = (state == ST_HEADER) && (rx_header == `CMD_API_VERSION);
    end
  end

  // Message FSM and settings
  always_ff @(posedge CLK) begin
    if (rst) begin
      state                <= ST_HEADER;
      word_idx             <= '0;
      push                 <= 1'b0;
      version_pending      <= 1'b0;
      settings.enable      <= 1'b0;
      settings.clk_divisor <= `DEFAULT_CLK_DIVISOR;
    end else begin
      push            <= 1'b0;
      version_pending <= version_next;
      if (word_valid) begin
        case (state)
          ST_HEADER: begin
            case (rx_header)
              `CMD_MOVE: begin
                state    <= ST_MOVE;
                word_idx <= 2'd1;
              end
              `CMD_ENABLE: settings.enable <= rx_word[0];
              `CMD_CLK_DIVISOR: begin
                // Zero would stall the DDA, treat as 1
                settings.clk_divisor <= (rx_word[7:0] == 8'd0) ? 8'd1 : rx_word[7:0];
              end
              `CMD_API_VERSION: state <= ST_DUMMY;
              // Unknown headers fall through
              default: state <= ST_HEADER;
            endcase
          end
          ST_MOVE: begin
            word_idx <= word_idx + 2'd1;
            // Third word completes the record
            if (word_idx == 2'd3) begin
              push  <= 1'b1;
              state <= ST_HEADER;
            end
          end
          // Dummy word carries the version reply
          default: state <= ST_HEADER;
        endcase
      end
    end
  end

  // Move record and reply word
  always_ff @(posedge CLK) begin
    // Live encoder count unless a version reply is owed
    send_word <= version_next ? version_word : encoder_count;
    if (word_valid) begin
      if (state == ST_HEADER) begin
        if (rx_header == `CMD_MOVE) begin
          move.dir <= rx_word[0];
        end
      end else if (state == ST_MOVE) begin
        case (word_idx)
          2'd1:    move.duration <= rx_word;
          2'd2:    move.increment <= rx_word;
          default: move.increment_increment <= rx_word;
        endcase
      end
    end
  end

endmodule

// ==== logic/move_queue.sv ====
`timescale 1ns/1ps
`include "stepper_cfg.svh"

module move_queue #(
  parameter int DEPTH = `MOVE_QUEUE_DEPTH
) (
  input  logic               CLK,
  input  logic               rst,
  input  logic               push,
  input  stepper_pkg::move_t move,
  input  logic               pop,
  output logic               available,
  output stepper_pkg::move_t head
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // Record storage, pointers wrap on power-of-two depth
  stepper_pkg::move_t mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0] occupancy;
  logic full;

  assign full      = (occupancy == (PTR_W + 1)'(DEPTH));
  assign available = (occupancy != '0);
  // Oldest record, readable the cycle after its push
  assign head      = mem[rd_ptr];

  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wr_ptr] <= move;
    end
  end

  // Pointers and fill level
  always_ff @(posedge CLK) begin
    if (rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      occupancy <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   occupancy <= occupancy + 1'b1;
        2'b01:   occupancy <= occupancy - 1'b1;
        default: occupancy <= occupancy;
      endcase
    end
  end

  // Host paces moves, decoder never overfills
  assert property (@(posedge CLK) disable iff (rst) push |-> !full);
  // DDA only pops a waiting move
  assert property (@(posedge CLK) disable iff (rst) pop |-> available);

endmodule

// ==== logic/dda_stepper.sv ====
`timescale 1ns/1ps
`include "stepper_cfg.svh"

module dda_stepper (
  input  logic                   CLK,
  input  logic                   rst,
  input  logic                   available,
  input  stepper_pkg::move_t     head,
  input  stepper_pkg::settings_t settings,
  output logic                   pop,
  output logic                   step,
  output logic                   dir
);

  // Move in progress
  stepper_pkg::move_t cur;
  logic busy;
  logic first_tick;
  // CLK cycles within the current tick
  stepper_pkg::divisor_t div_count;
  logic [63:0] ticks_left;
  stepper_pkg::count_t rate;
  stepper_pkg::count_t accum;
  stepper_pkg::count_t rate_next;
  stepper_pkg::count_t accum_sum;
  logic tick;

  // Take the next move as soon as idle
  assign pop  = !busy && available;
  // Divisor is never zero, >= keeps a lowered divisor from wrapping
  assign tick = busy && (div_count >= settings.clk_divisor - 8'd1);

  // Rate ramp and accumulator for this tick
  always_comb begin
    rate_next = first_tick ? cur.increment : rate + cur.increment_increment;
    accum_sum = accum + rate_next;
  end

  // Sequencing, step and dir
  always_ff @(posedge CLK) begin
    if (rst) begin
      busy       <= 1'b0;
      first_tick <= 1'b0;
      div_count  <= '0;
      ticks_left <= '0;
      step       <= 1'b0;
      dir        <= 1'b0;
    end else begin
      step <= 1'b0;
      if (pop) begin
        // Zero-length move finishes at once
        busy       <= (head.duration != 64'd0);
        first_tick <= 1'b1;
        div_count  <= '0;
        ticks_left <= head.duration;
        dir        <= head.dir;
      end else if (tick) begin
        div_count  <= '0;
        first_tick <= 1'b0;
        ticks_left <= ticks_left - 64'd1;
        busy       <= (ticks_left != 64'd1);
        // Ticks keep running while disabled, pulses do not
        step       <= settings.enable && (accum_sum > 64'sd0);
      end else if (busy) begin
        div_count <= div_count + 8'd1;
      end
    end
  end

  // Move record and DDA state
  always_ff @(posedge CLK) begin
    if (pop) begin
      cur   <= head;
      accum <= '0;
    end else if (tick) begin
      rate <= rate_next;
      if (accum_sum > 64'sd0) begin
        accum <= accum_sum - $signed(`STEP_THRESHOLD);
      end else begin
        accum <= accum_sum;
      end
    end
  end

  // Single-cycle pulse unless ticks are back to back
  assert property (@(posedge CLK) disable iff (rst)
    (step && (settings.clk_divisor != 8'd1)) |=> !step);

endmodule

// ==== logic/quad_encoder.sv ====
`timescale 1ns/1ps

module quad_encoder (
  input  logic                CLK,
  input  logic                rst,
  input  logic                enc_a,
  input  logic                enc_b,
  output stepper_pkg::count_t count,
  output logic                fault
);

  // Input synchronizers and last sampled state
  logic [1:0] a_sync;
  logic [1:0] b_sync;
  logic a_prev;
  logic b_prev;
  logic a_edge;
  logic b_edge;
  logic count_up;

  // Settle during reset, so no spurious edge on release
  always_ff @(posedge CLK) begin
    a_sync <= {a_sync[0], enc_a};
    b_sync <= {b_sync[0], enc_b};
    a_prev <= a_sync[1];
    b_prev <= b_sync[1];
  end

  assign a_edge   = a_sync[1] ^ a_prev;
  assign b_edge   = b_sync[1] ^ b_prev;
  // A leading B, e.g. 00 -> 10 -> 11 -> 01, counts up
  assign count_up = a_sync[1] ^ b_prev;

  always_ff @(posedge CLK) begin
    if (rst) begin
      count <= '0;
      fault <= 1'b0;
    end else if (a_edge && b_edge) begin
      // Skipped Gray state, direction unknown, sticky
      fault <= 1'b1;
    end else if (a_edge || b_edge) begin
      count <= count_up ? count + 64'sd1 : count - 64'sd1;
    end
  end

endmodule

// ==== logic/stepper_top.sv ====
`timescale 1ns/1ps

module stepper_top (
  input  logic CLK,
  input  logic rst,
  input  logic sck,
  input  logic cs,
  input  logic copi,
  output logic cipo,
  input  logic enc_a,
  input  logic enc_b,
  output logic step,
  output logic dir,
  output logic enable,
  output logic encoder_fault
);

  // SPI word path
  stepper_pkg::word_t rx_word;
  stepper_pkg::word_t send_word;
  logic word_valid;
  // Decoder to queue and DDA
  stepper_pkg::move_t move;
  stepper_pkg::move_t head;
  stepper_pkg::settings_t settings;
  logic push;
  logic pop;
  logic available;
  // Position for the reply word
  stepper_pkg::count_t encoder_count;

  // External driver enable
  assign enable = settings.enable;

  spi_word_rx spi_word_rx_inst (
    .CLK(CLK), .rst(rst), .sck(sck), .cs(cs), .copi(copi), .cipo(cipo),
    .send_word(send_word), .rx_word(rx_word), .word_valid(word_valid)
  );

  command_decoder command_decoder_inst (
    .CLK(CLK), .rst(rst), .word_valid(word_valid), .rx_word(rx_word),
    .encoder_count(encoder_count), .send_word(send_word), .push(push),
    .move(move), .settings(settings)
  );

  move_queue move_queue_inst (
    .CLK(CLK), .rst(rst), .push(push), .move(move), .pop(pop),
    .available(available), .head(head)
  );

  dda_stepper dda_stepper_inst (
    .CLK(CLK), .rst(rst), .available(available), .head(head),
    .settings(settings), .pop(pop), .step(step), .dir(dir)
  );

  quad_encoder quad_encoder_inst (
    .CLK(CLK), .rst(rst), .enc_a(enc_a), .enc_b(enc_b),
    .count(encoder_count), .fault(encoder_fault)
  );

endmodule

// ==== test/stepper_tb.sv ====
`timescale 1ns/1ps
`include "stepper_cfg.svh"

module stepper_tb;

  // SCK half period in CLK cycles, SCK = CLK/16
  localparam int SPI_HALF = 8;

  logic CLK;
  logic rst;
  logic sck;
  logic cs;
  logic copi;
  logic cipo;
  logic enc_a;
  logic enc_b;
  logic step;
  logic dir;
  logic enable;
  logic encoder_fault;

  logic [63:0] rng;
  logic [63:0] reply;
  logic [1:0] enc_phase;
  // Step interval check, active only during the divisor move
  logic gap_check_on;
  int unsigned gap_div;
  int unsigned gap;
  logic seen_step;
  int unsigned step_total;
  logic fault_expected;

  stepper_top stepper_top_inst (
    .CLK(CLK), .rst(rst), .sck(sck), .cs(cs), .copi(copi), .cipo(cipo),
    .enc_a(enc_a), .enc_b(enc_b), .step(step), .dir(dir), .enable(enable),
    .encoder_fault(encoder_fault)
  );

  always #50 CLK = ~CLK;

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic expect_equal(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
    assert (actual === expected) else begin
      stop_with_failure($sformatf("MISMATCH %s expected 0x%h actual 0x%h",
                                  name, expected, actual));
    end
  endtask

  // 64-bit LCG, Knuth constants
  function automatic logic [63:0] lcg_next(input logic [63:0] state);
    return state * 64'd6364136223846793005 + 64'd1442695040888963407;
  endfunction

  // Reference DDA, step count for one move with the driver enabled
  function automatic int unsigned model_steps(input logic [63:0] duration,
                                              input logic signed [63:0] inc,
                                              input logic signed [63:0] inc_inc);
    logic signed [63:0] rate;
    logic signed [63:0] accum;
    logic [63:0] t;
    int unsigned steps;
    rate = inc;
    accum = '0;
    steps = 0;
    for (t = 0; t < duration; t++) begin
      // Ramp starts on the second tick
      if (t != 64'd0) begin
        rate = rate + inc_inc;
      end
      accum = accum + rate;
      if (accum > 64'sd0) begin
        steps++;
        accum = accum - $signed(`STEP_THRESHOLD);
      end
    end
    return steps;
  endfunction

  // Gray order 00 10 11 01, A leads B going up
  function automatic logic [1:0] gray_pins(input logic [1:0] phase);
    case (phase)
      2'd0:    return 2'b00;
      2'd1:    return 2'b10;
      2'd2:    return 2'b11;
      default: return 2'b01;
    endcase
  endfunction

  // Returns 1 ns after a rising edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge CLK);
    #1;
  endtask

  // One 64-bit mode 0 frame, MSB first
  task automatic spi_transfer(input logic [63:0] tx, output logic [63:0] rx);
    rx = '0;
    cs = 1'b0;
    wait_cycles(SPI_HALF);
    for (int i = 63; i >= 0; i--) begin
      copi = tx[i];
      wait_cycles(SPI_HALF);
      // CIPO settled since the last falling SCK
      rx[i] = cipo;
      sck = 1'b1;
      wait_cycles(SPI_HALF);
      sck = 1'b0;
    end
    wait_cycles(SPI_HALF);
    cs = 1'b1;
    wait_cycles(SPI_HALF);
  endtask

  task automatic run_move(input logic mv_dir, input logic [63:0] duration,
                          input logic signed [63:0] inc, input logic signed [63:0] inc_inc,
                          input int div, input logic driver_on);
    int unsigned expected;
    int unsigned start;
    // No pulses at all while the driver is off
    expected = driver_on ? model_steps(duration, inc, inc_inc) : 0;
    start = step_total;
    spi_transfer({`CMD_MOVE, 55'd0, mv_dir}, reply);
    spi_transfer(duration, reply);
    spi_transfer(inc, reply);
    spi_transfer(inc_inc, reply);
    // Load latency plus exactly duration ticks of div cycles
    wait_cycles(int'(duration) * div + 32);
    expect_equal("step_count", 64'(expected), 64'(step_total - start));
    expect_equal("dir", {63'd0, mv_dir}, {63'd0, dir});
  endtask

  task automatic encoder_steps(input int count, input logic forward);
    for (int i = 0; i < count; i++) begin
      enc_phase = forward ? enc_phase + 2'd1 : enc_phase - 2'd1;
      {enc_a, enc_b} = gray_pins(enc_phase);
      wait_cycles(4);
    end
  endtask

  task automatic wait_for_enable(input logic level);
    int n;
    n = 0;
    while (enable !== level && n < 100) begin
      wait_cycles(1);
      n++;
    end
    if (enable !== level) begin
      stop_with_failure("timeout waiting for the enable pin to follow CMD_ENABLE");
    end
  endtask

  task automatic wait_for_fault();
    int n;
    n = 0;
    while (!encoder_fault && n < 50) begin
      wait_cycles(1);
      n++;
    end
    if (!encoder_fault) begin
      stop_with_failure("timeout waiting for encoder_fault after a double input change");
    end
  endtask

  // Step counter and interval between pulses
  always @(posedge CLK) begin
    if (rst) begin
      step_total <= 0;
      gap <= 0;
      seen_step <= 1'b0;
    end else begin
      gap <= gap + 1;
      if (!gap_check_on) begin
        seen_step <= 1'b0;
      end
      if (step) begin
        step_total <= step_total + 1;
        gap <= 1;
        seen_step <= gap_check_on;
        if (gap_check_on && seen_step) begin
          assert (gap % gap_div == 0) else begin
            stop_with_failure($sformatf("step interval of %0d cycles is not a multiple of %0d",
                                        gap, gap_div));
          end
        end
      end
    end
  end

  assert property (@(posedge CLK) disable iff (rst) !enable |=> !step)
    else stop_with_failure("step pulse while the driver was disabled");
  assert property (@(posedge CLK) disable iff (rst) step |=> !step)
    else stop_with_failure("step pulse longer than one cycle");
  assert property (@(posedge CLK) disable iff (rst) encoder_fault |=> encoder_fault)
    else stop_with_failure("encoder_fault cleared without a reset");
  assert property (@(posedge CLK) disable iff (rst) !fault_expected |-> !encoder_fault)
    else stop_with_failure("encoder_fault set without a double input change");

  initial begin
    int clk_div;
    int n_fwd;
    int n_back;
    longint expected_count;
    logic [63:0] mv_duration;
    logic signed [63:0] mv_inc;
    logic signed [63:0] mv_inc_inc;
    CLK = 1'b0;
    rst = 1'b1;
    sck = 1'b0;
    cs = 1'b1;
    copi = 1'b0;
    enc_a = 1'b0;
    enc_b = 1'b0;
    enc_phase = 2'd0;
    gap_check_on = 1'b0;
    gap_div = 1;
    fault_expected = 1'b0;
    rng = 64'd65;
    reply = '0;
    wait_cycles(8);
    rst = 1'b0;
    wait_cycles(4);
    expect_equal("step", 64'd0, {63'd0, step});
    expect_equal("enable", 64'd0, {63'd0, enable});
    expect_equal("encoder_fault", 64'd0, {63'd0, encoder_fault});

    // Version reply comes in the dummy frame
    spi_transfer({`CMD_API_VERSION, 56'd0}, reply);
    expect_equal("reply", 64'd0, reply);
    spi_transfer(64'd0, reply);
    expect_equal("version_reply", {40'd0, `VERSION_MAJOR, `VERSION_MINOR, `VERSION_PATCH}, reply);

    // Enable on, off, then on for the moves
    spi_transfer({`CMD_ENABLE, 55'd0, 1'b1}, reply);
    wait_for_enable(1'b1);
    spi_transfer({`CMD_ENABLE, 55'd0, 1'b0}, reply);
    wait_for_enable(1'b0);
    // Disabled move, ticks run out with no pulses
    run_move(1'b1, 64'd8, 64'sh4000000000000000, 64'sd0, int'(`DEFAULT_CLK_DIVISOR), 1'b0);
    spi_transfer({`CMD_ENABLE, 55'd0, 1'b1}, reply);
    wait_for_enable(1'b1);

    // Random moves at the reset divisor, first one at constant rate
    for (int m = 0; m < 4; m++) begin
      rng = lcg_next(rng);
      mv_duration = 64'd8 + {59'd0, rng[36:32]};
      rng = lcg_next(rng);
      mv_inc = {2'b00, rng[63:2]};
      rng = lcg_next(rng);
      mv_inc_inc = (m == 0) ? 64'sd0 : {{8{rng[63]}}, rng[63:8]};
      run_move(rng[5], mv_duration, mv_inc, mv_inc_inc, int'(`DEFAULT_CLK_DIVISOR), 1'b1);
    end

    // New divisor, intervals of a constant-rate move
    rng = lcg_next(rng);
    clk_div = 3 + int'(rng[42:40]);
    spi_transfer({`CMD_CLK_DIVISOR, 48'd0, 8'(clk_div)}, reply);
    gap_div = clk_div;
    gap_check_on = 1'b1;
    rng = lcg_next(rng);
    mv_inc = {3'b001, rng[60:0]};
    run_move(rng[63], 64'd40, mv_inc, 64'sd0, clk_div, 1'b1);
    gap_check_on = 1'b0;

    // Forward then backward quadrature steps
    rng = lcg_next(rng);
    n_fwd = 5 + int'(rng[36:32]);
    n_back = int'(rng[44:41]);
    encoder_steps(n_fwd, 1'b1);
    encoder_steps(n_back, 1'b0);
    wait_cycles(8);
    spi_transfer(64'd0, reply);
    expected_count = longint'(n_fwd) - longint'(n_back);
    expect_equal("encoder_reply", expected_count, reply);

    // Both inputs in one cycle
    fault_expected = 1'b1;
    {enc_a, enc_b} = ~{enc_a, enc_b};
    wait_for_fault();
    wait_cycles(20);
    expect_equal("encoder_fault", 64'd1, {63'd0, encoder_fault});

    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+logic
logic/stepper_pkg.sv
logic/spi_word_rx.sv
logic/command_decoder.sv
logic/move_queue.sv
logic/dda_stepper.sv
logic/quad_encoder.sv
logic/stepper_top.sv
test/stepper_tb.sv

// ==== Makefile ====
# Verilator build and run of the stepper controller testbench

VERILATOR ?= verilator
TOP       ?= stepper_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= TEST PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
